//--- hw/cpu16_pkg.sv
`default_nettype none

package cpu16_pkg;

	// one machine word, used for instructions, data and addresses
	typedef logic [15:0] word_t;

	// index into the four-entry register file
	typedef logic [1:0] reg_addr_t;

	// opcode field, inst[15:12]
	typedef logic [3:0] opcode_t;

	// r-type function field, inst[5:0]
	typedef logic [5:0] funct_t;

	// opcodes that the engine executes
	// anything else retires as a no-op
	localparam opcode_t OP_ADI   = 4'd4;
	localparam opcode_t OP_ORI   = 4'd5;
	localparam opcode_t OP_LHI   = 4'd6;
	localparam opcode_t OP_RTYPE = 4'd15;

	// r-type function codes
	// 0 to 7 are the alu group and write rd
	localparam funct_t FN_ADD = 6'd0;
	localparam funct_t FN_SUB = 6'd1;
	localparam funct_t FN_AND = 6'd2;
	localparam funct_t FN_ORR = 6'd3;
	localparam funct_t FN_NOT = 6'd4;
	localparam funct_t FN_TCP = 6'd5;
	localparam funct_t FN_SHL = 6'd6;
	localparam funct_t FN_SHR = 6'd7;

	// special r-type codes, no register write
	localparam funct_t FN_WWD = 6'd28;
	localparam funct_t FN_HLT = 6'd29;

	// field layout
	//   rs  = inst[11:10]
	//   rt  = inst[9:8]
	//   rd  = inst[7:6]
	//   imm = inst[7:0]

	// first fetch address after reset
	localparam word_t PC_RESET = 16'h0000;

endpackage

`default_nettype wire

//--- hw/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  cpu16_pkg::word_t  a,
	input  cpu16_pkg::word_t  b,
	// r-type function code, immediates are mapped onto add and orr
	input  cpu16_pkg::funct_t op,
	output cpu16_pkg::word_t  result
);

	always_comb begin
		case (op)
			// add and sub drop the carry, plain 16 bit wrap
			cpu16_pkg::FN_ADD: begin
				result = a + b;
			end
			cpu16_pkg::FN_SUB: begin
				result = a - b;
			end
			cpu16_pkg::FN_AND: begin
				result = a & b;
			end
			cpu16_pkg::FN_ORR: begin
				result = a | b;
			end
			// unary ops only look at a
			cpu16_pkg::FN_NOT: begin
				result = ~a;
			end
			// two's complement, 0x8000 maps back to itself
			cpu16_pkg::FN_TCP: begin
				result = ~a + 16'd1;
			end
			// logical shifts by one, zero fill
			cpu16_pkg::FN_SHL: begin
				result = {a[14:0], 1'b0};
			end
			cpu16_pkg::FN_SHR: begin
				result = {1'b0, a[15:1]};
			end
			// wwd, hlt and unknown codes
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- hw/inst_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module inst_fetch (
	input  logic             clk,
	input  logic             arst_n,
	// queue has no room for another word
	input  logic             full,
	// instruction memory side
	input  logic             ready_m1,
	input  cpu16_pkg::word_t data1,
	output logic             read_m1,
	output cpu16_pkg::word_t address1,
	// queue write side
	output logic             push,
	output cpu16_pkg::word_t push_data
);

	// program counter
	cpu16_pkg::word_t pc;

	// goes high one edge after reset release so that
	// the memory sees no request while reset is applied
	logic run;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			run <= 1'b0;
		end else begin
			run <= 1'b1;
		end
	end

	// ask memory whenever the queue can take a word
	assign read_m1 = run & ~full;

	// word is taken on an edge where both levels are high
	assign push = read_m1 & ready_m1;

	// memory word goes to the queue untouched
	assign push_data = data1;

	// pc moves only on an accepted word
	// a low ready_m1 just holds the same address
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= cpu16_pkg::PC_RESET;
		end else if (push) begin
			pc <= pc + 16'd1;
		end
	end

	assign address1 = pc;

endmodule

`default_nettype wire

//--- hw/inst_queue.sv
`timescale 1ns/1ps
`default_nettype none

module inst_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic             clk,
	input  logic             arst_n,
	// write side, from fetch
	input  logic             push,
	input  cpu16_pkg::word_t push_data,
	// read side, to execute
	input  logic             pop,
	output cpu16_pkg::word_t head,
	output logic             empty,
	output logic             full
);

	// pointer width, depth is a power of two so pointers wrap on their own
	localparam int PTR_W = $clog2(QUEUE_DEPTH);

	cpu16_pkg::word_t mem [QUEUE_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	// occupancy, one bit wider than the pointers so that full is representable
	logic [PTR_W:0]   count;

	logic do_push;
	logic do_pop;

	assign empty = (count == '0);
	assign full  = (count == (PTR_W+1)'(QUEUE_DEPTH));

	// pop on an empty queue is dropped
	assign do_pop  = pop & ~empty;
	// a full queue still takes a word if the head leaves on the same edge
	assign do_push = push & (~full | do_pop);

	// oldest entry is always visible
	assign head = mem[rd_ptr];

	// storage, no reset on the payload
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// count holds when both happen
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
	input  logic             clk,
	input  logic             arst_n,
	// queue read side
	input  cpu16_pkg::word_t head,
	input  logic             empty,
	output logic             pop,
	// retired count, wwd port and halt status
	output cpu16_pkg::word_t num_inst,
	output cpu16_pkg::word_t output_port,
	output logic             is_halted
);

	// register file
	cpu16_pkg::word_t rf [4];

	// decoded fields of the head word
	cpu16_pkg::opcode_t  opcode;
	cpu16_pkg::funct_t   funct;
	cpu16_pkg::reg_addr_t rs;
	cpu16_pkg::reg_addr_t rt;
	cpu16_pkg::reg_addr_t rd;
	logic [7:0]          imm;

	logic is_rtype;
	logic is_adi;
	logic is_ori;
	logic is_lhi;
	logic is_wwd;
	logic is_hlt;

	// alu hookup
	cpu16_pkg::funct_t alu_op;
	cpu16_pkg::word_t  alu_b;
	cpu16_pkg::word_t  alu_res;

	// writeback
	logic                 wr_en;
	cpu16_pkg::reg_addr_t wr_addr;
	cpu16_pkg::word_t     wr_data;

	assign opcode = head[15:12];
	assign funct  = head[5:0];
	assign rs     = head[11:10];
	assign rt     = head[9:8];
	assign rd     = head[7:6];
	assign imm    = head[7:0];

	assign is_rtype = (opcode == cpu16_pkg::OP_RTYPE);
	assign is_adi   = (opcode == cpu16_pkg::OP_ADI);
	assign is_ori   = (opcode == cpu16_pkg::OP_ORI);
	assign is_lhi   = (opcode == cpu16_pkg::OP_LHI);
	assign is_wwd   = is_rtype & (funct == cpu16_pkg::FN_WWD);
	assign is_hlt   = is_rtype & (funct == cpu16_pkg::FN_HLT);

	// retire one word per cycle until halt
	assign pop = ~empty & ~is_halted;

	// immediates reuse add and orr, r-type passes its own code
	always_comb begin
		if (is_adi) begin
			alu_op = cpu16_pkg::FN_ADD;
			alu_b  = {{8{imm[7]}}, imm};
		end else if (is_ori) begin
			alu_op = cpu16_pkg::FN_ORR;
			alu_b  = {8'h00, imm};
		end else begin
			alu_op = funct;
			alu_b  = rf[rt];
		end
	end

	alu u_alu (
		.a      (rf[rs]),
		.b      (alu_b),
		.op     (alu_op),
		.result (alu_res)
	);

	// immediate forms target rt, r-type arithmetic targets rd
	assign wr_en   = pop & (is_adi | is_ori | is_lhi |
		(is_rtype & (funct <= cpu16_pkg::FN_SHR)));
	assign wr_addr = is_rtype ? rd : rt;
	// lhi bypasses the alu
	assign wr_data = is_lhi ? {imm, 8'h00} : alu_res;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rf[0] <= '0;
			rf[1] <= '0;
			rf[2] <= '0;
			rf[3] <= '0;
		end else if (wr_en) begin
			rf[wr_addr] <= wr_data;
		end
	end

	// count, port and halt all update on the retiring edge
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			num_inst    <= '0;
			output_port <= '0;
			is_halted   <= 1'b0;
		end else if (pop) begin
			// every popped word counts, hlt and no-ops too
			num_inst <= num_inst + 16'd1;
			if (is_wwd) begin
				output_port <= rf[rs];
			end
			if (is_hlt) begin
				is_halted <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/cpu16_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu16_top #(
	// entries between fetch and execute, power of two, 2 or more
	parameter int QUEUE_DEPTH = 4
) (
	input  logic             clk,
	input  logic             arst_n,
	// instruction memory
	output logic             read_m1,
	output cpu16_pkg::word_t address1,
	input  logic             ready_m1,
	input  cpu16_pkg::word_t data1,
	// status and output
	output cpu16_pkg::word_t num_inst,
	output cpu16_pkg::word_t output_port,
	output logic             is_halted
);

	// fetch to queue
	logic             push;
	cpu16_pkg::word_t push_data;
	logic             full;

	// queue to execute
	logic             pop;
	cpu16_pkg::word_t head;
	logic             empty;

	inst_fetch u_fetch (
		.clk       (clk),
		.arst_n    (arst_n),
		.full      (full),
		.ready_m1  (ready_m1),
		.data1     (data1),
		.read_m1   (read_m1),
		.address1  (address1),
		.push      (push),
		.push_data (push_data)
	);

	inst_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) u_queue (
		.clk       (clk),
		.arst_n    (arst_n),
		.push      (push),
		.push_data (push_data),
		.pop       (pop),
		.head      (head),
		.empty     (empty),
		.full      (full)
	);

	exec_unit u_exec (
		.clk         (clk),
		.arst_n      (arst_n),
		.head        (head),
		.empty       (empty),
		.pop         (pop),
		.num_inst    (num_inst),
		.output_port (output_port),
		.is_halted   (is_halted)
	);

endmodule

`default_nettype wire

//--- tb/cpu16_assert.sv
`timescale 1ns/1ps
`default_nettype none

module cpu16_assert #(
	parameter int QUEUE_DEPTH = 4
) (
	input logic                         clk,
	input logic                         arst_n,
	// fetch and queue handshake as seen in the top level
	input logic                         pop,
	input logic                         full,
	input logic                         read_m1,
	// queue occupancy
	input logic [$clog2(QUEUE_DEPTH):0] count
);

	// failures seen so far, read by the testbench at the end of the run
	int error_count = 0;

	// a full queue with no pop neither takes a word nor loses one
	full_without_pop: assert property (@(posedge clk) disable iff (!arst_n)
		(full && !pop) |=> full)
	else begin
		$error("full queue changed its occupancy without a pop");
		error_count++;
	end

	// occupancy stays within the storage
	count_in_range: assert property (@(posedge clk) disable iff (!arst_n)
		count <= QUEUE_DEPTH)
	else begin
		$error("queue count %0d is above the depth %0d", count, QUEUE_DEPTH);
		error_count++;
	end

	// no memory request while reset is applied
	no_read_in_reset: assert property (@(posedge clk) !arst_n |-> !read_m1)
	else begin
		$error("read_m1 is high during reset");
		error_count++;
	end

endmodule

`default_nettype wire

//--- tb/cpu16_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu16_tb;

	localparam int QUEUE_DEPTH = 4;
	localparam int MEM_WORDS   = 128;
	// lhi, ori, lhi, ori, op, wwd
	localparam int ROW_WORDS   = 6;
	localparam int HALT_HOLD   = 20;

	logic             clk;
	logic             arst_n;
	logic             ready_m1;
	cpu16_pkg::word_t data1;
	logic             read_m1;
	cpu16_pkg::word_t address1;
	cpu16_pkg::word_t num_inst;
	cpu16_pkg::word_t output_port;
	logic             is_halted;

	// test table, one entry per row in each queue
	string             row_name [$];
	logic              row_adi  [$];
	cpu16_pkg::funct_t row_fn   [$];
	cpu16_pkg::word_t  row_a    [$];
	cpu16_pkg::word_t  row_b    [$];
	cpu16_pkg::word_t  row_exp  [$];

	cpu16_pkg::word_t prog_mem [MEM_WORDS];
	int               prog_len;
	int               cycle_limit;
	int               cycles;
	int               pass_count;
	int               fail_count;
	logic [31:0]      rng_state;

	cpu16_top #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) dut0 (
		.clk         (clk),
		.arst_n      (arst_n),
		.read_m1     (read_m1),
		.address1    (address1),
		.ready_m1    (ready_m1),
		.data1       (data1),
		.num_inst    (num_inst),
		.output_port (output_port),
		.is_halted   (is_halted)
	);

	// queue rules and reset behavior of fetch, count taken from inside the queue
	bind cpu16_top cpu16_assert #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_assert (
		.clk     (clk),
		.arst_n  (arst_n),
		.pop     (pop),
		.full    (full),
		.read_m1 (read_m1),
		.count   (u_queue.count)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// memory ready, high about three cycles in four
	initial begin
		rng_state = 32'h4004f446;
		forever begin
			@(posedge clk);
			rng_state = xorshift32(rng_state);
			ready_m1 <= (rng_state[1:0] != 2'b00);
		end
	end

	// asynchronous read port of the instruction memory
	always_comb begin
		if (address1 < 16'(MEM_WORDS)) begin
			data1 = prog_mem[address1];
		end else begin
			data1 = address1 ^ 16'hc3c3;
		end
	end

	// run limit, checked every cycle
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Timeout after %0d cycles, only %0d instructions retired",
				cycles, num_inst);
			$display("Regression failed");
			$finish;
		end
	end

	task automatic add_row(input string name, input logic adi, input cpu16_pkg::funct_t fn,
		input cpu16_pkg::word_t a, input cpu16_pkg::word_t b, input cpu16_pkg::word_t exp);
		row_name.push_back(name);
		row_adi.push_back(adi);
		row_fn.push_back(fn);
		row_a.push_back(a);
		row_b.push_back(b);
		row_exp.push_back(exp);
	endtask

	// immediate format, op rs rt imm8
	function automatic cpu16_pkg::word_t enc_imm(input cpu16_pkg::opcode_t op,
		input cpu16_pkg::reg_addr_t rs, input cpu16_pkg::reg_addr_t rt, input logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// r-type format, op rs rt rd funct
	function automatic cpu16_pkg::word_t enc_rtype(input cpu16_pkg::reg_addr_t rs,
		input cpu16_pkg::reg_addr_t rt, input cpu16_pkg::reg_addr_t rd,
		input cpu16_pkg::funct_t fn);
		return {cpu16_pkg::OP_RTYPE, rs, rt, rd, fn};
	endfunction

	task automatic assemble_program();
		int i;
		int base;
		for (i = 0; i < MEM_WORDS; i++) begin
			prog_mem[i] = 16'(i) ^ 16'hc3c3;
		end
		for (i = 0; i < row_name.size(); i++) begin
			base = ROW_WORDS * i;
			// a into r0, b into r1
			prog_mem[base + 0] = enc_imm(cpu16_pkg::OP_LHI, 2'd0, 2'd0, row_a[i][15:8]);
			prog_mem[base + 1] = enc_imm(cpu16_pkg::OP_ORI, 2'd0, 2'd0, row_a[i][7:0]);
			prog_mem[base + 2] = enc_imm(cpu16_pkg::OP_LHI, 2'd0, 2'd1, row_b[i][15:8]);
			prog_mem[base + 3] = enc_imm(cpu16_pkg::OP_ORI, 2'd1, 2'd1, row_b[i][7:0]);
			// result always lands in r2
			if (row_adi[i]) begin
				prog_mem[base + 4] = enc_imm(cpu16_pkg::OP_ADI, 2'd0, 2'd2, row_b[i][7:0]);
			end else begin
				prog_mem[base + 4] = enc_rtype(2'd0, 2'd1, 2'd2, row_fn[i]);
			end
			prog_mem[base + 5] = enc_rtype(2'd2, 2'd0, 2'd0, cpu16_pkg::FN_WWD);
		end
		prog_len = ROW_WORDS * row_name.size() + 1;
		prog_mem[prog_len - 1] = enc_rtype(2'd0, 2'd0, 2'd0, cpu16_pkg::FN_HLT);
	endtask

	task automatic check_value(input string name, input cpu16_pkg::word_t expected,
		input cpu16_pkg::word_t actual);
		if (actual === expected) begin
			pass_count++;
			$display("ok %s: %h", name, actual);
		end else begin
			fail_count++;
			$display("Mismatch %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// sampled on the falling edge, away from the retiring edge
	task automatic wait_retired(input int target);
		while (num_inst < target) begin
			@(negedge clk);
		end
	endtask

	initial begin
		int i;
		int target;
		cpu16_pkg::word_t prev;
		arst_n      = 1'b0;
		ready_m1    = 1'b0;
		cycles      = 0;
		cycle_limit = 0;
		pass_count  = 0;
		fail_count  = 0;

		// name, adi, function, a, b, expected
		add_row("add",      1'b0, cpu16_pkg::FN_ADD, 16'h1234, 16'h4321, 16'h5555);
		add_row("add_wrap", 1'b0, cpu16_pkg::FN_ADD, 16'hffff, 16'h0002, 16'h0001);
		add_row("sub",      1'b0, cpu16_pkg::FN_SUB, 16'h5000, 16'h1234, 16'h3dcc);
		add_row("sub_wrap", 1'b0, cpu16_pkg::FN_SUB, 16'h0001, 16'h0003, 16'hfffe);
		add_row("and",      1'b0, cpu16_pkg::FN_AND, 16'hf0f0, 16'h3c3c, 16'h3030);
		add_row("orr",      1'b0, cpu16_pkg::FN_ORR, 16'ha500, 16'h005a, 16'ha55a);
		add_row("not",      1'b0, cpu16_pkg::FN_NOT, 16'h0f0f, 16'h1234, 16'hf0f0);
		add_row("tcp",      1'b0, cpu16_pkg::FN_TCP, 16'h0001, 16'h0000, 16'hffff);
		add_row("tcp_min",  1'b0, cpu16_pkg::FN_TCP, 16'h8000, 16'h0000, 16'h8000);
		add_row("shl",      1'b0, cpu16_pkg::FN_SHL, 16'h8001, 16'h0000, 16'h0002);
		add_row("shr",      1'b0, cpu16_pkg::FN_SHR, 16'h8001, 16'h0000, 16'h4000);
		// negative immediate lowers the value
		add_row("adi_neg",  1'b1, cpu16_pkg::FN_ADD, 16'h0100, 16'h00fe, 16'h00fe);
		add_row("adi_pos",  1'b1, cpu16_pkg::FN_ADD, 16'h7fff, 16'h0001, 16'h8000);

		assemble_program();
		cycle_limit = 20 * prog_len;

		repeat (8) @(posedge clk);
		arst_n <= 1'b1;

		prev = 16'h0000;
		for (i = 0; i < row_name.size(); i++) begin
			target = ROW_WORDS * (i + 1);
			// op retired, wwd not yet, port still holds the last row
			wait_retired(target - 1);
			check_value({row_name[i], "_hold"}, prev, output_port);
			wait_retired(target);
			check_value(row_name[i], row_exp[i], output_port);
			prev = row_exp[i];
		end

		while (!is_halted) begin
			@(negedge clk);
		end
		check_value("halt_count", 16'(prog_len), num_inst);
		// halted unit stops popping, so the queue fills and fetch stops
		repeat (HALT_HOLD) @(negedge clk);
		check_value("halt_hold", 16'(prog_len), num_inst);
		check_value("halt_read", 16'h0000, {15'b0, read_m1});

		$display("%0d checks passed, %0d failed, %0d assertion failures",
			pass_count, fail_count, dut0.u_assert.error_count);
		if (fail_count == 0 && dut0.u_assert.error_count == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- cpu16.f
hw/cpu16_pkg.sv
hw/alu.sv
hw/inst_fetch.sv
hw/inst_queue.sv
hw/exec_unit.sv
hw/cpu16_top.sv
tb/cpu16_assert.sv
tb/cpu16_tb.sv
